//--- Bender.yml
package:
  name: x86_wb

sources:
  - include_dirs:
      - .
    files:
      - x86_wb_pkg.sv
      - wb_mem_if.sv
      - wb_commit_stage.sv
      - wb_dest_decode.sv
      - wb_mem_master.sv
      - x86_wb_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_x86_wb_top.sv

//--- tb_x86_wb_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "x86_wb_macros.svh"

module tb_x86_wb_top;

   localparam int MAX_CASES = 16;
   localparam int TIMEOUT   = 40;

   // operand flags {a_addr, a_reg, a_seg, a_mmx, b_reg, b_addr, stack}
   localparam logic [6:0] F_A_ADDR = 7'b1000000;
   localparam logic [6:0] F_A_REG  = 7'b0100000;
   localparam logic [6:0] F_A_SEG  = 7'b0010000;
   localparam logic [6:0] F_A_MMX  = 7'b0001000;
   localparam logic [6:0] F_B_REG  = 7'b0000100;
   localparam logic [6:0] F_B_ADDR = 7'b0000010;
   localparam logic [6:0] F_STACK  = 7'b0000001;

   // expected strobes {reg, reg2, seg, mmx, stack, mem}
   localparam logic [5:0] E_REG   = 6'b100000;
   localparam logic [5:0] E_REG2  = 6'b010000;
   localparam logic [5:0] E_SEG   = 6'b001000;
   localparam logic [5:0] E_MMX   = 6'b000100;
   localparam logic [5:0] E_STACK = 6'b000010;
   localparam logic [5:0] E_MEM   = 6'b000001;

   logic                        clk;
   logic                        rst_n;
   logic                        ex_valid;
   logic                        ex_ready;
   logic [`REG_NUM_W-1:0]       ex_dest_reg;
   logic [`WB_ADDR_W-1:0]       ex_dest_address;
   logic [`WB_DATA_W-1:0]       ex_result;
   x86_wb_pkg::op_size_e        ex_opsize;
   x86_wb_pkg::alu_op_e         ex_alu_op;
   logic                        ex_op_a_is_address;
   logic                        ex_op_a_is_reg;
   logic                        ex_op_a_is_segment;
   logic                        ex_op_a_is_mmx;
   logic [`REG_NUM_W-1:0]       ex_op_b_reg;
   logic [`WB_ADDR_W-1:0]       ex_op_b_address;
   logic                        ex_op_b_is_reg;
   logic                        ex_op_b_is_address;
   logic                        ex_stack;
   x86_wb_pkg::stack_op_e       ex_stack_op;
   logic                        dec_wb_valid;
   logic [`REG_NUM_W-1:0]       dec_wb_reg;
   logic [`REG_DATA_W-1:0]      dec_wb_data;
   x86_wb_pkg::op_size_e        dec_wb_size;
   logic                        reg_wr_en;
   logic [`REG_NUM_W-1:0]       reg_wr_num;
   x86_wb_pkg::op_size_e        reg_wr_size;
   logic [`REG_DATA_W-1:0]      reg_wr_data;
   logic                        reg2_wr_en;
   logic [`REG_NUM_W-1:0]       reg2_wr_num;
   logic [`REG_DATA_W-1:0]      reg2_wr_data;
   logic                        seg_wr_en;
   logic [`REG_NUM_W-1:0]       seg_wr_num;
   logic [`SEG_DATA_W-1:0]      seg_wr_data;
   logic                        mmx_wr_en;
   logic [`REG_NUM_W-1:0]       mmx_wr_num;
   logic [`WB_DATA_W-1:0]       mmx_wr_data;
   logic                        stack_wr_en;
   x86_wb_pkg::stack_op_e       stack_wr_op;
   x86_wb_pkg::op_size_e        stack_wr_size;
   logic                        mem_cyc;
   logic                        mem_stb;
   logic                        mem_we;
   logic [`WB_ADDR_W-1:0]       mem_adr;
   logic [`WB_DATA_W-1:0]       mem_dat;
   logic [`WB_SEL_W-1:0]        mem_sel;
   logic                        mem_ack;

   // stimulus and expected values with one row per test
   logic [`REG_NUM_W-1:0]       t_dest_reg [MAX_CASES];
   logic [`WB_ADDR_W-1:0]       t_dest_adr [MAX_CASES];
   logic [`WB_DATA_W-1:0]       t_result   [MAX_CASES];
   x86_wb_pkg::op_size_e        t_size     [MAX_CASES];
   x86_wb_pkg::alu_op_e         t_alu      [MAX_CASES];
   logic [6:0]                  t_flags    [MAX_CASES];
   logic [`REG_NUM_W-1:0]       t_b_reg    [MAX_CASES];
   logic [`WB_ADDR_W-1:0]       t_b_adr    [MAX_CASES];
   x86_wb_pkg::stack_op_e       t_stack_op [MAX_CASES];
   int                          t_hold     [MAX_CASES];
   logic [5:0]                  t_mask     [MAX_CASES];
   logic [`REG_DATA_W-1:0]      t_rdata    [MAX_CASES];
   logic [`REG_DATA_W-1:0]      t_r2data   [MAX_CASES];
   logic [`WB_ADDR_W-1:0]       t_adr      [MAX_CASES];
   logic [`WB_DATA_W-1:0]       t_dat      [MAX_CASES];
   logic [`WB_SEL_W-1:0]        t_sel      [MAX_CASES];

   int     n_cases;
   int     cur_test;
   int     test_errs;
   int     pass_cnt;
   int     fail_cnt;
   int     cnt_reg;
   int     cnt_reg2;
   int     cnt_seg;
   int     cnt_mmx;
   int     cnt_stack;
   int     cnt_mem;
   int     cnt_cyc;
   int     reg_cyc;
   int     ack_cyc;
   int     ack_wait;
   bit     hung;
   integer seed = 14755;

   x86_wb_top dut0 (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // wishbone slave with 0 to 3 wait states per cycle
   initial begin
      mem_ack  = 1'b0;
      ack_wait = -1;
      forever begin
         @(negedge clk);
         if (!rst_n || mem_ack) begin
            mem_ack  = 1'b0;
            ack_wait = -1;
         end else if (mem_cyc && mem_stb) begin
            if (ack_wait < 0) begin
               ack_wait = $unsigned($random(seed)) % 4;
            end
            if (ack_wait == 0) begin
               mem_ack = 1'b1;
            end else begin
               ack_wait--;
            end
         end
      end
   end

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("ERR test %0d %s got %h expected %h", cur_test, name, got, exp);
         test_errs++;
      end
   endtask

   task automatic add_case(
      input logic [2:0]  dest_reg,
      input logic [31:0] dest_adr,
      input logic [63:0] result,
      input x86_wb_pkg::op_size_e size,
      input x86_wb_pkg::alu_op_e alu,
      input logic [6:0]  flags,
      input logic [2:0]  b_reg,
      input logic [31:0] b_adr,
      input x86_wb_pkg::stack_op_e sop,
      input int          hold,
      input logic [5:0]  mask,
      input logic [31:0] rdata,
      input logic [31:0] r2data,
      input logic [31:0] adr,
      input logic [63:0] dat,
      input logic [7:0]  sel
   );
      t_dest_reg[n_cases] = dest_reg;
      t_dest_adr[n_cases] = dest_adr;
      t_result[n_cases]   = result;
      t_size[n_cases]     = size;
      t_alu[n_cases]      = alu;
      t_flags[n_cases]    = flags;
      t_b_reg[n_cases]    = b_reg;
      t_b_adr[n_cases]    = b_adr;
      t_stack_op[n_cases] = sop;
      t_hold[n_cases]     = hold;
      t_mask[n_cases]     = mask;
      t_rdata[n_cases]    = rdata;
      t_r2data[n_cases]   = r2data;
      t_adr[n_cases]      = adr;
      t_dat[n_cases]      = dat;
      t_sel[n_cases]      = sel;
      n_cases++;
   endtask

   task automatic build_table();
      n_cases = 0;
      add_case(3'd3, 32'h0, 64'h11223344_55667788, x86_wb_pkg::SIZE_DWORD, x86_wb_pkg::ALU_MOV,
               F_A_REG, 3'd0, 32'h0, x86_wb_pkg::STACK_NONE, 0,
               E_REG, 32'h55667788, 32'h0, 32'h0, 64'h0, 8'h00);
      add_case(3'd0, 32'h1000, 64'hCAFEBABE_12345678, x86_wb_pkg::SIZE_DWORD, x86_wb_pkg::ALU_MOV,
               F_A_ADDR, 3'd0, 32'h0, x86_wb_pkg::STACK_NONE, 0,
               E_MEM, 32'h0, 32'h0, 32'h1000, 64'hCAFEBABE_12345678, 8'h0F);
      add_case(3'd0, 32'h1004, 64'h00000000_000000A5, x86_wb_pkg::SIZE_BYTE, x86_wb_pkg::ALU_MOV,
               F_A_ADDR, 3'd0, 32'h0, x86_wb_pkg::STACK_NONE, 0,
               E_MEM, 32'h0, 32'h0, 32'h1004, 64'h00000000_000000A5, 8'h01);
      add_case(3'd0, 32'h1008, 64'h00000000_0000BEEF, x86_wb_pkg::SIZE_WORD, x86_wb_pkg::ALU_ADD,
               F_A_ADDR, 3'd0, 32'h0, x86_wb_pkg::STACK_NONE, 0,
               E_MEM, 32'h0, 32'h0, 32'h1008, 64'h00000000_0000BEEF, 8'h03);
      add_case(3'd0, 32'h1010, 64'h01234567_89ABCDEF, x86_wb_pkg::SIZE_QWORD, x86_wb_pkg::ALU_MOV,
               F_A_ADDR, 3'd0, 32'h0, x86_wb_pkg::STACK_NONE, 0,
               E_MEM, 32'h0, 32'h0, 32'h1010, 64'h01234567_89ABCDEF, 8'hFF);
      // exchange register with register and then register with memory
      add_case(3'd1, 32'h0, 64'hAAAA0001_BBBB0002, x86_wb_pkg::SIZE_DWORD, x86_wb_pkg::ALU_XCHG,
               F_A_REG | F_B_REG, 3'd6, 32'h0, x86_wb_pkg::STACK_NONE, 0,
               E_REG | E_REG2, 32'hBBBB0002, 32'hAAAA0001, 32'h0, 64'h0, 8'h00);
      add_case(3'd2, 32'h0, 64'h0BADF00D_13579BDF, x86_wb_pkg::SIZE_DWORD, x86_wb_pkg::ALU_XCHG,
               F_A_REG | F_B_ADDR, 3'd0, 32'h2000, x86_wb_pkg::STACK_NONE, 0,
               E_REG | E_MEM, 32'h13579BDF, 32'h0, 32'h2000, 64'h00000000_0BADF00D, 8'h0F);
      add_case(3'd2, 32'h0, 64'h55550000_0000ABCD, x86_wb_pkg::SIZE_WORD, x86_wb_pkg::ALU_MOV,
               F_A_SEG, 3'd0, 32'h0, x86_wb_pkg::STACK_NONE, 0,
               E_SEG, 32'h0, 32'h0, 32'h0, 64'h0, 8'h00);
      add_case(3'd4, 32'h0, 64'hFEDCBA98_76543210, x86_wb_pkg::SIZE_QWORD, x86_wb_pkg::ALU_MOV,
               F_A_MMX, 3'd0, 32'h0, x86_wb_pkg::STACK_NONE, 0,
               E_MMX, 32'h0, 32'h0, 32'h0, 64'h0, 8'h00);
      add_case(3'd0, 32'h0, 64'h0, x86_wb_pkg::SIZE_DWORD, x86_wb_pkg::ALU_SUB,
               F_STACK, 3'd0, 32'h0, x86_wb_pkg::STACK_PUSH, 0,
               E_STACK, 32'h0, 32'h0, 32'h0, 64'h0, 8'h00);
      add_case(3'd5, 32'h0, 64'h00000000_00C0FFEE, x86_wb_pkg::SIZE_DWORD, x86_wb_pkg::ALU_MOV,
               F_A_REG | F_STACK, 3'd0, 32'h0, x86_wb_pkg::STACK_POP, 0,
               E_REG | E_STACK, 32'h00C0FFEE, 32'h0, 32'h0, 64'h0, 8'h00);
      // decode holds port 1 for three cycles
      add_case(3'd7, 32'h0, 64'h00000000_0F0F0F0F, x86_wb_pkg::SIZE_DWORD, x86_wb_pkg::ALU_ADD,
               F_A_REG, 3'd0, 32'h0, x86_wb_pkg::STACK_NONE, 3,
               E_REG, 32'h0F0F0F0F, 32'h0, 32'h0, 64'h0, 8'h00);
   endtask

   task automatic apply_case(input int i);
      ex_dest_reg        = t_dest_reg[i];
      ex_dest_address    = t_dest_adr[i];
      ex_result          = t_result[i];
      ex_opsize          = t_size[i];
      ex_alu_op          = t_alu[i];
      ex_op_a_is_address = t_flags[i][6];
      ex_op_a_is_reg     = t_flags[i][5];
      ex_op_a_is_segment = t_flags[i][4];
      ex_op_a_is_mmx     = t_flags[i][3];
      ex_op_b_is_reg     = t_flags[i][2];
      ex_op_b_is_address = t_flags[i][1];
      ex_stack           = t_flags[i][0];
      ex_op_b_reg        = t_b_reg[i];
      ex_op_b_address    = t_b_adr[i];
      ex_stack_op        = t_stack_op[i];
      dec_wb_valid       = (t_hold[i] > 0);
      dec_wb_reg         = 3'd5;
      dec_wb_data        = 32'hDEC0_0000 + i;
      dec_wb_size        = x86_wb_pkg::SIZE_WORD;
      ex_valid           = 1'b1;
   endtask

   // called just after a rising edge to see the values of the ending cycle
   task automatic sample_outputs(input int i, input int cyc);
      if (dec_wb_valid) begin
         check_val("reg_wr_en", reg_wr_en, 1);
         check_val("reg_wr_num", reg_wr_num, dec_wb_reg);
         check_val("reg_wr_size", reg_wr_size, dec_wb_size);
         check_val("reg_wr_data", reg_wr_data, dec_wb_data);
      end else if (reg_wr_en) begin
         cnt_reg++;
         reg_cyc = cyc;
         check_val("reg_wr_num", reg_wr_num, t_dest_reg[i]);
         check_val("reg_wr_size", reg_wr_size, t_size[i]);
         check_val("reg_wr_data", reg_wr_data, t_rdata[i]);
      end
      if (reg2_wr_en) begin
         cnt_reg2++;
         check_val("reg2_wr_num", reg2_wr_num, t_b_reg[i]);
         check_val("reg2_wr_data", reg2_wr_data, t_r2data[i]);
      end
      if (seg_wr_en) begin
         cnt_seg++;
         check_val("seg_wr_num", seg_wr_num, t_dest_reg[i]);
         check_val("seg_wr_data", seg_wr_data, t_result[i][15:0]);
      end
      if (mmx_wr_en) begin
         cnt_mmx++;
         check_val("mmx_wr_num", mmx_wr_num, t_dest_reg[i]);
         check_val("mmx_wr_data", mmx_wr_data, t_result[i]);
      end
      if (stack_wr_en) begin
         cnt_stack++;
         check_val("stack_wr_op", stack_wr_op, t_stack_op[i]);
         check_val("stack_wr_size", stack_wr_size, t_size[i]);
      end
      if (mem_cyc) begin
         cnt_cyc++;
         check_val("mem_stb", mem_stb, 1);
         check_val("mem_we", mem_we, 1);
         if (mem_ack) begin
            cnt_mem++;
            ack_cyc = cyc;
            check_val("mem_adr", mem_adr, t_adr[i]);
            check_val("mem_dat", mem_dat, t_dat[i]);
            check_val("mem_sel", mem_sel, t_sel[i]);
         end
      end
   endtask

   task automatic run_case(input int i);
      int  waited;
      int  cyc;
      bit  retired;
      cur_test  = i;
      test_errs = 0;
      cnt_reg   = 0;
      cnt_reg2  = 0;
      cnt_seg   = 0;
      cnt_mmx   = 0;
      cnt_stack = 0;
      cnt_mem   = 0;
      cnt_cyc   = 0;
      reg_cyc   = -1;
      ack_cyc   = -1;
      @(negedge clk);
      apply_case(i);
      waited = 0;
      @(posedge clk);
      while (!ex_ready && waited < TIMEOUT) begin
         waited++;
         @(posedge clk);
      end
      if (!ex_ready) begin
         $display("test %0d timed out waiting for ex_ready to accept the result", i);
         fail_cnt++;
         hung = 1;
         return;
      end
      @(negedge clk);
      ex_valid = 1'b0;
      cyc      = 0;
      retired  = 0;
      while (!retired && cyc < TIMEOUT) begin
         @(posedge clk);
         cyc++;
         sample_outputs(i, cyc);
         retired = ex_ready;
         if (!retired) begin
            @(negedge clk);
            if (cyc >= t_hold[i]) begin
               dec_wb_valid = 1'b0;
            end
         end
      end
      if (!retired) begin
         $display("test %0d timed out waiting for the entry to retire", i);
         fail_cnt++;
         hung = 1;
         return;
      end
      check_val("reg_wr_en count", cnt_reg, t_mask[i][5]);
      check_val("reg2_wr_en count", cnt_reg2, t_mask[i][4]);
      check_val("seg_wr_en count", cnt_seg, t_mask[i][3]);
      check_val("mmx_wr_en count", cnt_mmx, t_mask[i][2]);
      check_val("stack_wr_en count", cnt_stack, t_mask[i][1]);
      check_val("mem_ack count", cnt_mem, t_mask[i][0]);
      if (t_mask[i][0]) begin
         if (ack_cyc != cyc) begin
            $display("test %0d retired in cycle %0d but mem_ack came in cycle %0d",
                     i, cyc, ack_cyc);
            test_errs++;
         end
         if (t_mask[i][5] && reg_cyc != cyc) begin
            $display("test %0d register write was not in the retire cycle", i);
            test_errs++;
         end
      end else begin
         // a stray request would reach the bus one cycle after retire
         @(posedge clk);
         if (mem_cyc) begin
            cnt_cyc++;
         end
         check_val("mem_cyc cycles", cnt_cyc, 0);
         if (cyc != t_hold[i] + 1) begin
            $display("test %0d retired in cycle %0d, expected cycle %0d", i, cyc, t_hold[i] + 1);
            test_errs++;
         end
      end
      if (test_errs == 0) begin
         pass_cnt++;
         $display("test %0d ok", i);
      end else begin
         fail_cnt++;
         $display("test %0d failed with %0d errors", i, test_errs);
      end
   endtask

   task automatic check_reset();
      cur_test  = -1;
      test_errs = 0;
      check_val("ex_ready", ex_ready, 1);
      check_val("reg_wr_en", reg_wr_en, 0);
      check_val("reg2_wr_en", reg2_wr_en, 0);
      check_val("seg_wr_en", seg_wr_en, 0);
      check_val("mmx_wr_en", mmx_wr_en, 0);
      check_val("stack_wr_en", stack_wr_en, 0);
      check_val("mem_cyc", mem_cyc, 0);
      check_val("mem_stb", mem_stb, 0);
      check_val("mem_we", mem_we, 0);
      if (test_errs == 0) begin
         pass_cnt++;
         $display("reset test ok");
      end else begin
         fail_cnt++;
         $display("reset test failed with %0d errors", test_errs);
      end
   endtask

   initial begin
      rst_n        = 1'b0;
      hung         = 0;
      pass_cnt     = 0;
      fail_cnt     = 0;
      build_table();
      apply_case(0);
      ex_valid     = 1'b0;
      dec_wb_valid = 1'b0;
      repeat (4) @(negedge clk);
      rst_n = 1'b1;
      check_reset();
      for (int i = 0; i < n_cases && !hung; i++) begin
         run_case(i);
      end
      $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && !hung) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
x86_wb_pkg.sv
wb_mem_if.sv
wb_commit_stage.sv
wb_dest_decode.sv
wb_mem_master.sv
x86_wb_top.sv
tb_x86_wb_top.sv

//--- wb_commit_stage.sv
`timescale 1ns/10ps
`default_nettype none

module wb_commit_stage (
   input  wire                        clk,
   input  wire                        rst_n,

   input  wire                        in_valid,
   output logic                       in_ready,
   input  wire x86_wb_pkg::commit_entry_t in_entry,

   output x86_wb_pkg::commit_entry_t  entry,
   output logic                       entry_valid,

   input  wire                        need_mem,
   input  wire                        port1_blocked,
   input  wire                        mem_done,

   output logic                       retire
);

   logic mem_only_done;

   // memory part finishes alone when port 1 is taken by decode
   assign mem_only_done = entry_valid && need_mem && mem_done && port1_blocked;

   assign retire = entry_valid && !port1_blocked && (!need_mem || mem_done);

   // empty or leaving this cycle
   assign in_ready = !entry_valid || retire;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         entry_valid <= 1'b0;
      end else if (in_ready) begin
         entry_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         entry <= in_entry;
      end else if (mem_only_done) begin
         // write is on the bus already
         // keep only the register part pending
         entry.op_a_is_address <= 1'b0;
         entry.op_b_is_address <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- wb_dest_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "x86_wb_macros.svh"

module wb_dest_decode (
   input  wire x86_wb_pkg::commit_entry_t entry,
   input  wire                        entry_valid,
   input  wire                        retire,

   input  wire                        dec_wb_valid,
   input  wire [`REG_NUM_W-1:0]       dec_wb_reg,
   input  wire [`REG_DATA_W-1:0]      dec_wb_data,
   input  wire x86_wb_pkg::op_size_e  dec_wb_size,

   output logic                       need_mem,
   output logic                       port1_blocked,

   output logic                       reg_wr_en,
   output logic [`REG_NUM_W-1:0]      reg_wr_num,
   output x86_wb_pkg::op_size_e       reg_wr_size,
   output logic [`REG_DATA_W-1:0]     reg_wr_data,

   output logic                       reg2_wr_en,
   output logic [`REG_NUM_W-1:0]      reg2_wr_num,
   output logic [`REG_DATA_W-1:0]     reg2_wr_data,

   output logic                       seg_wr_en,
   output logic [`REG_NUM_W-1:0]      seg_wr_num,
   output logic [`SEG_DATA_W-1:0]     seg_wr_data,

   output logic                       mmx_wr_en,
   output logic [`REG_NUM_W-1:0]      mmx_wr_num,
   output logic [`WB_DATA_W-1:0]      mmx_wr_data,

   output logic                       stack_wr_en,
   output x86_wb_pkg::stack_op_e      stack_wr_op,
   output x86_wb_pkg::op_size_e       stack_wr_size,

   wb_mem_if.commit                   mem
);

   logic                  is_xchg;
   logic                  xchg_to_mem;
   logic [`REG_DATA_W-1:0] result_hi;

   assign is_xchg     = (entry.alu_op == x86_wb_pkg::ALU_XCHG);
   assign xchg_to_mem = is_xchg && entry.op_b_is_address;
   assign result_hi   = entry.result[`WB_DATA_W-1:`REG_DATA_W];

   // memory request held until the master reports done
   assign need_mem = entry_valid && (entry.op_a_is_address || xchg_to_mem);
   assign mem.req  = need_mem;
   assign mem.size = entry.opsize;
   assign mem.adr  = xchg_to_mem ? entry.op_b_address : entry.dest_address;
   assign mem.dat  = xchg_to_mem ? {{(`WB_DATA_W-`REG_DATA_W){1'b0}}, result_hi}
                                 : entry.result;

   // decode owns port 1 whenever it asks
   assign port1_blocked = dec_wb_valid && entry_valid && entry.op_a_is_reg;

   always_comb begin
      if (dec_wb_valid) begin
         reg_wr_en   = 1'b1;
         reg_wr_num  = dec_wb_reg;
         reg_wr_size = dec_wb_size;
         reg_wr_data = dec_wb_data;
      end else begin
         reg_wr_en   = retire && entry.op_a_is_reg;
         reg_wr_num  = entry.dest_reg;
         reg_wr_size = entry.opsize;
         reg_wr_data = entry.result[`REG_DATA_W-1:0];
      end
   end

   // second half of an exchange
   assign reg2_wr_en   = retire && is_xchg && entry.op_b_is_reg;
   assign reg2_wr_num  = entry.op_b_reg;
   assign reg2_wr_data = result_hi;

   assign seg_wr_en   = retire && entry.op_a_is_segment;
   assign seg_wr_num  = entry.dest_reg;
   assign seg_wr_data = entry.result[`SEG_DATA_W-1:0];

   assign mmx_wr_en   = retire && entry.op_a_is_mmx;
   assign mmx_wr_num  = entry.dest_reg;
   assign mmx_wr_data = entry.result;

   assign stack_wr_en   = retire && entry.stack;
   assign stack_wr_op   = entry.stack_op;
   assign stack_wr_size = entry.opsize;

endmodule

`default_nettype wire

//--- wb_mem_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "x86_wb_macros.svh"

interface wb_mem_if;

   logic                  req;
   logic [`WB_ADDR_W-1:0] adr;
   logic [`WB_DATA_W-1:0] dat;
   x86_wb_pkg::op_size_e  size;

   // high for the single cycle the slave acks
   logic                  done;

   modport commit (
      output req,
      output adr,
      output dat,
      output size,
      input  done
   );

   modport master (
      input  req,
      input  adr,
      input  dat,
      input  size,
      output done
   );

endinterface

`default_nettype wire

//--- wb_mem_master.sv
`timescale 1ns/10ps
`default_nettype none

`include "x86_wb_macros.svh"

module wb_mem_master (
   input  wire                    clk,
   input  wire                    rst_n,

   wb_mem_if.master               mem,

   output logic                   mem_cyc,
   output logic                   mem_stb,
   output logic                   mem_we,
   output logic [`WB_ADDR_W-1:0]  mem_adr,
   output logic [`WB_DATA_W-1:0]  mem_dat,
   output logic [`WB_SEL_W-1:0]   mem_sel,
   input  wire                    mem_ack
);

   x86_wb_pkg::mem_state_e state;
   logic                   busy;

   function automatic logic [`WB_SEL_W-1:0] size_to_sel(input x86_wb_pkg::op_size_e size);
      logic [`WB_SEL_W-1:0] sel;
      case (size)
         x86_wb_pkg::SIZE_BYTE:  sel = 8'h01;
         x86_wb_pkg::SIZE_WORD:  sel = 8'h03;
         x86_wb_pkg::SIZE_DWORD: sel = 8'h0F;
         default:                sel = 8'hFF;
      endcase
      return sel;
   endfunction

   assign busy = (state == x86_wb_pkg::MEM_BUSY);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= x86_wb_pkg::MEM_IDLE;
      end else begin
         case (state)
            x86_wb_pkg::MEM_IDLE: begin
               if (mem.req) begin
                  state <= x86_wb_pkg::MEM_BUSY;
               end
            end
            default: begin
               // single beat that ends on the first ack
               if (mem_ack) begin
                  state <= x86_wb_pkg::MEM_IDLE;
               end
            end
         endcase
      end
   end

   // bus fields stay frozen for the whole cycle
   always_ff @(posedge clk) begin
      if (!busy && mem.req) begin
         mem_adr <= mem.adr;
         mem_dat <= mem.dat;
         mem_sel <= size_to_sel(mem.size);
      end
   end

   assign mem_cyc  = busy;
   assign mem_stb  = busy;
   assign mem_we   = busy;
   assign mem.done = busy && mem_ack;

endmodule

`default_nettype wire

//--- x86_wb_macros.svh
`ifndef X86_WB_MACROS_SVH
`define X86_WB_MACROS_SVH

// memory side of the commit stage
`define WB_ADDR_W 32

// execute result and memory write data
`define WB_DATA_W 64

// one lane per byte of WB_DATA_W
`define WB_SEL_W 8

// general register file write port
`define REG_DATA_W 32

// segment registers
`define SEG_DATA_W 16

// register numbers for gpr, segment and mmx files
`define REG_NUM_W 3

`endif

//--- x86_wb_pkg.sv
`default_nettype none

`include "x86_wb_macros.svh"

package x86_wb_pkg;

   // alu opcodes as carried on the decode channel
   typedef enum logic [3:0] {
      ALU_ADD  = 4'd0,
      ALU_OR   = 4'd1,
      ALU_ADC  = 4'd2,
      ALU_SBB  = 4'd3,
      ALU_AND  = 4'd4,
      ALU_SUB  = 4'd5,
      ALU_XOR  = 4'd6,
      ALU_CMP  = 4'd7,
      ALU_MOV  = 4'd8,
      ALU_XCHG = 4'd14
   } alu_op_e;

   typedef enum logic [2:0] {
      SIZE_BYTE  = 3'd0,
      SIZE_WORD  = 3'd1,
      SIZE_DWORD = 3'd2,
      SIZE_QWORD = 3'd3
   } op_size_e;

   typedef enum logic [1:0] {
      STACK_NONE = 2'd0,
      STACK_PUSH = 2'd1,
      STACK_POP  = 2'd2
   } stack_op_e;

   typedef enum logic {
      MEM_IDLE = 1'b0,
      MEM_BUSY = 1'b1
   } mem_state_e;

   // one completed execute result waiting to retire
   typedef struct packed {
      logic [`REG_NUM_W-1:0] dest_reg;
      logic [`WB_ADDR_W-1:0] dest_address;
      logic [`WB_DATA_W-1:0] result;
      op_size_e              opsize;
      alu_op_e               alu_op;
      logic                  op_a_is_address;
      logic                  op_a_is_reg;
      logic                  op_a_is_segment;
      logic                  op_a_is_mmx;
      logic [`REG_NUM_W-1:0] op_b_reg;
      logic [`WB_ADDR_W-1:0] op_b_address;
      logic                  op_b_is_reg;
      logic                  op_b_is_address;
      logic                  stack;
      stack_op_e             stack_op;
   } commit_entry_t;

endpackage

`default_nettype wire

//--- x86_wb_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "x86_wb_macros.svh"

module x86_wb_top (
   input  wire                        clk,
   input  wire                        rst_n,

   input  wire                        ex_valid,
   output logic                       ex_ready,
   input  wire [`REG_NUM_W-1:0]       ex_dest_reg,
   input  wire [`WB_ADDR_W-1:0]       ex_dest_address,
   input  wire [`WB_DATA_W-1:0]       ex_result,
   input  wire x86_wb_pkg::op_size_e  ex_opsize,
   input  wire x86_wb_pkg::alu_op_e   ex_alu_op,
   input  wire                        ex_op_a_is_address,
   input  wire                        ex_op_a_is_reg,
   input  wire                        ex_op_a_is_segment,
   input  wire                        ex_op_a_is_mmx,
   input  wire [`REG_NUM_W-1:0]       ex_op_b_reg,
   input  wire [`WB_ADDR_W-1:0]       ex_op_b_address,
   input  wire                        ex_op_b_is_reg,
   input  wire                        ex_op_b_is_address,
   input  wire                        ex_stack,
   input  wire x86_wb_pkg::stack_op_e ex_stack_op,

   input  wire                        dec_wb_valid,
   input  wire [`REG_NUM_W-1:0]       dec_wb_reg,
   input  wire [`REG_DATA_W-1:0]      dec_wb_data,
   input  wire x86_wb_pkg::op_size_e  dec_wb_size,

   output logic                       reg_wr_en,
   output logic [`REG_NUM_W-1:0]      reg_wr_num,
   output x86_wb_pkg::op_size_e       reg_wr_size,
   output logic [`REG_DATA_W-1:0]     reg_wr_data,
   output logic                       reg2_wr_en,
   output logic [`REG_NUM_W-1:0]      reg2_wr_num,
   output logic [`REG_DATA_W-1:0]     reg2_wr_data,
   output logic                       seg_wr_en,
   output logic [`REG_NUM_W-1:0]      seg_wr_num,
   output logic [`SEG_DATA_W-1:0]     seg_wr_data,
   output logic                       mmx_wr_en,
   output logic [`REG_NUM_W-1:0]      mmx_wr_num,
   output logic [`WB_DATA_W-1:0]      mmx_wr_data,
   output logic                       stack_wr_en,
   output x86_wb_pkg::stack_op_e      stack_wr_op,
   output x86_wb_pkg::op_size_e       stack_wr_size,

   output logic                       mem_cyc,
   output logic                       mem_stb,
   output logic                       mem_we,
   output logic [`WB_ADDR_W-1:0]      mem_adr,
   output logic [`WB_DATA_W-1:0]      mem_dat,
   output logic [`WB_SEL_W-1:0]       mem_sel,
   input  wire                        mem_ack
);

   x86_wb_pkg::commit_entry_t ex_entry;
   x86_wb_pkg::commit_entry_t entry;
   logic                      entry_valid;
   logic                      need_mem;
   logic                      port1_blocked;
   logic                      retire;

   wb_mem_if mem_if ();

   always_comb begin
      ex_entry.dest_reg        = ex_dest_reg;
      ex_entry.dest_address    = ex_dest_address;
      ex_entry.result          = ex_result;
      ex_entry.opsize          = ex_opsize;
      ex_entry.alu_op          = ex_alu_op;
      ex_entry.op_a_is_address = ex_op_a_is_address;
      ex_entry.op_a_is_reg     = ex_op_a_is_reg;
      ex_entry.op_a_is_segment = ex_op_a_is_segment;
      ex_entry.op_a_is_mmx     = ex_op_a_is_mmx;
      ex_entry.op_b_reg        = ex_op_b_reg;
      ex_entry.op_b_address    = ex_op_b_address;
      ex_entry.op_b_is_reg     = ex_op_b_is_reg;
      ex_entry.op_b_is_address = ex_op_b_is_address;
      ex_entry.stack           = ex_stack;
      ex_entry.stack_op        = ex_stack_op;
   end

   wb_commit_stage u_commit (
      .clk           (clk),
      .rst_n         (rst_n),
      .in_valid      (ex_valid),
      .in_ready      (ex_ready),
      .in_entry      (ex_entry),
      .entry         (entry),
      .entry_valid   (entry_valid),
      .need_mem      (need_mem),
      .port1_blocked (port1_blocked),
      .mem_done      (mem_if.done),
      .retire        (retire)
   );

   wb_dest_decode u_decode (
      .entry         (entry),
      .entry_valid   (entry_valid),
      .retire        (retire),
      .dec_wb_valid  (dec_wb_valid),
      .dec_wb_reg    (dec_wb_reg),
      .dec_wb_data   (dec_wb_data),
      .dec_wb_size   (dec_wb_size),
      .need_mem      (need_mem),
      .port1_blocked (port1_blocked),
      .reg_wr_en     (reg_wr_en),
      .reg_wr_num    (reg_wr_num),
      .reg_wr_size   (reg_wr_size),
      .reg_wr_data   (reg_wr_data),
      .reg2_wr_en    (reg2_wr_en),
      .reg2_wr_num   (reg2_wr_num),
      .reg2_wr_data  (reg2_wr_data),
      .seg_wr_en     (seg_wr_en),
      .seg_wr_num    (seg_wr_num),
      .seg_wr_data   (seg_wr_data),
      .mmx_wr_en     (mmx_wr_en),
      .mmx_wr_num    (mmx_wr_num),
      .mmx_wr_data   (mmx_wr_data),
      .stack_wr_en   (stack_wr_en),
      .stack_wr_op   (stack_wr_op),
      .stack_wr_size (stack_wr_size),
      .mem           (mem_if.commit)
   );

   wb_mem_master u_master (
      .clk     (clk),
      .rst_n   (rst_n),
      .mem     (mem_if.master),
      .mem_cyc (mem_cyc),
      .mem_stb (mem_stb),
      .mem_we  (mem_we),
      .mem_adr (mem_adr),
      .mem_dat (mem_dat),
      .mem_sel (mem_sel),
      .mem_ack (mem_ack)
   );

endmodule

`default_nettype wire
